// File: flist.f
+incdir+dv
hdl/jtag_dbg_pkg.sv
hdl/jtag_tap.sv
hdl/dbg_reg_bank.sv
hdl/jtag_dbg_top.sv
dv/tb_jtag_dbg.sv

// File: dv/jtag_tb_tasks.svh
// JTAG driver tasks and reference model for the debug port testbench
`ifndef JTAG_TB_TASKS_SVH
`define JTAG_TB_TASKS_SVH

////////////////////////////////////////////////////////////
// TAP drivers

// One TCK cycle with the given TMS value
task automatic tms_step(input logic tms_val);
    @(negedge tck);
    tms = tms_val;
    @(posedge tck);
endtask

// Five ones reach Test-Logic-Reset from any state, then park in idle
task automatic tap_reset();
    repeat (5) tms_step(1'b1);
    tms_step(1'b0);
    model_ir = IR_IDCODE;
endtask

// Shift n bits LSB first and return to idle
task automatic shift_bits(input int n, input logic [63:0] din, output logic [63:0] dout);
    dout = '0;
    for (int i = 0; i < n; i++) begin
        @(negedge tck);
        tdi = din[i];
        tms = (i == n - 1);             // Last bit moves on to Exit1
        @(posedge tck);
        dout[i] = tdo;                  // Sampled before the shift
    end
    tms_step(1'b1);                     // Exit1 to Update
    tms_step(1'b0);                     // Update to idle
endtask

task automatic ir_scan(input logic [IR_WIDTH-1:0] ir_in, output logic [IR_WIDTH-1:0] ir_out);
    logic [63:0] dout;
    tms_step(1'b1);                     // Select-DR
    tms_step(1'b1);                     // Select-IR
    tms_step(1'b0);                     // Capture-IR
    tms_step(1'b0);                     // Shift-IR
    shift_bits(IR_WIDTH, 64'(ir_in), dout);
    ir_out = dout[IR_WIDTH-1:0];
endtask

task automatic dr_scan(input int n, input logic [63:0] din, output logic [63:0] dout);
    tms_step(1'b1);                     // Select-DR
    tms_step(1'b0);                     // Capture-DR
    tms_step(1'b0);                     // Shift-DR
    shift_bits(n, din, dout);
endtask

////////////////////////////////////////////////////////////
// Reference model

// Value loaded at Capture-DR and the chain length for an instruction
function automatic logic [63:0] expected_capture(input logic [IR_WIDTH-1:0] ir,
                                                 output int len);
    case (ir)
        IR_IDCODE: begin
            len = 32;
            return 64'(TB_IDCODE);
        end
        IR_SCRATCH: begin
            len = 32;
            return 64'(model_scratch);
        end
        IR_CTRL: begin
            len = CTRL_WIDTH;
            return 64'(model_ctrl);
        end
        IR_STATUS: begin
            len = STATUS_WIDTH;
            return 64'(model_status);
        end
        default: begin
            len = 1;                    // Bypass, captures 0
            return '0;
        end
    endcase
endfunction

// TDO stream: captured bits first, then the input delayed by the chain length
function automatic logic [63:0] expected_tdo(input logic [63:0] cap, input int len,
                                             input logic [63:0] din, input int n);
    logic [63:0] res;
    res = '0;
    for (int i = 0; i < n; i++) begin
        res[i] = (i < len) ? cap[i] : din[i-len];
    end
    return res;
endfunction

`endif

// File: dv/tb_jtag_dbg.sv
// Testbench for the JTAG debug access port: scans checked against a register model
module tb_jtag_dbg
    import jtag_dbg_pkg::*;
();

    localparam int          CLK_PERIOD      = 40;
    localparam logic [31:0] TB_IDCODE       = 32'h1BEE_F0C3;
    // Roughly 2000 TCK edges of scanning over all tests, doubled
    localparam int          WATCHDOG_CYCLES = 4000;

    logic                    tck;
    logic                    trst_n;
    logic                    tms;
    logic                    tdi;
    logic                    tdo;
    logic [STATUS_WIDTH-1:0] status;
    logic [CTRL_WIDTH-1:0]   ctrl;

    // Model state
    logic [IR_WIDTH-1:0]     model_ir;
    logic [31:0]             model_scratch;
    logic [CTRL_WIDTH-1:0]   model_ctrl;
    logic [STATUS_WIDTH-1:0] model_status;

    // Results waiting for the compare process
    string       name_q[$];
    logic [63:0] exp_q[$];
    logic [63:0] act_q[$];
    int          pass_count = 0;
    int          fail_count = 0;

    `include "jtag_tb_tasks.svh"

    jtag_dbg_top #(
        .IDCODE   (TB_IDCODE)
    ) jtag_dbg_top_i (
        .tck_i    (tck),
        .trst_n_i (trst_n),
        .tms_i    (tms),
        .tdi_i    (tdi),
        .tdo_o    (tdo),
        .status_i (status),
        .ctrl_o   (ctrl)
    );

    initial begin
        tck = 1'b0;
        forever #(CLK_PERIOD / 2) tck = ~tck;
    end

    ////////////////////////////////////////////////////////////
    // Checking

    task automatic post_result(input string name, input logic [63:0] exp_v,
                               input logic [63:0] act_v);
        name_q.push_back(name);
        exp_q.push_back(exp_v);
        act_q.push_back(act_v);
    endtask

    initial begin
        string       name;
        logic [63:0] exp_v;
        logic [63:0] act_v;
        forever begin
            @(posedge tck);
            while (name_q.size() > 0) begin
                name  = name_q.pop_front();
                exp_v = exp_q.pop_front();
                act_v = act_q.pop_front();
                if (act_v !== exp_v) begin
                    $display("FAIL %s expected %h actual %h", name, exp_v, act_v);
                    fail_count++;
                end else begin
                    $display("PASS %s", name);
                    pass_count++;
                end
            end
        end
    end

    // DR scan checked against the model, then the model takes the write
    task automatic check_dr(input string name, input int n, input logic [63:0] din);
        int          len;
        logic [63:0] cap;
        logic [63:0] exp_v;
        logic [63:0] act_v;
        logic [63:0] wr;
        cap   = expected_capture(model_ir, len);
        exp_v = expected_tdo(cap, len, din, n);
        dr_scan(n, din, act_v);
        post_result(name, exp_v, act_v);
        wr = din >> (n - len);          // Last len bits stay in the chain
        case (model_ir)
            IR_SCRATCH: model_scratch = wr[31:0];
            IR_CTRL:    model_ctrl    = wr[CTRL_WIDTH-1:0];
            IR_STATUS:  model_status  = '0;         // Read clears, write ignored
            default:    ;
        endcase
    endtask

    // Capture-IR returns the instruction in force before the scan
    task automatic check_ir(input string name, input logic [IR_WIDTH-1:0] ir_new);
        logic [IR_WIDTH-1:0] act_v;
        ir_scan(ir_new, act_v);
        post_result(name, 64'(model_ir), 64'(act_v));
        model_ir = ir_new;
    endtask

    task automatic pulse_status(input int cycles);
        logic [STATUS_WIDTH-1:0] ev;
        repeat (cycles) begin
            @(negedge tck);
            ev           = STATUS_WIDTH'($urandom & $urandom);   // Sparse events
            status       = ev;
            model_status = model_status | ev;
        end
        @(negedge tck);
        status = '0;
    endtask

    // Leave Shift-DR with TMS high and keep going to Test-Logic-Reset.
    // The bits shifted in equal din, so the Update-DR on the way writes din back
    task automatic abort_shift_by_tms(input logic [31:0] din);
        tms_step(1'b1);
        tms_step(1'b0);
        tms_step(1'b0);
        for (int i = 0; i < 32; i++) begin
            @(negedge tck);
            tdi = din[i];
            tms = (i == 31);            // First of five ones
            @(posedge tck);
        end
        repeat (4) tms_step(1'b1);
        tms_step(1'b0);
        model_ir = IR_IDCODE;
    endtask

    ////////////////////////////////////////////////////////////
    // Tests

    initial begin
        logic [31:0]           word;
        logic [CTRL_WIDTH-1:0] ctrl_val;
        void'($urandom(54));
        trst_n        = 1'b0;
        tms           = 1'b1;
        tdi           = 1'b0;
        status        = '0;
        model_ir      = IR_IDCODE;
        model_scratch = '0;
        model_ctrl    = '0;
        model_status  = '0;
        repeat (10) @(negedge tck);
        trst_n = 1'b1;
        tap_reset();

        check_dr("idcode after reset", 32, 64'($urandom));
        check_ir("ir capture after reset", IR_IDCODE);

        check_ir("load bypass", IR_BYPASS);
        check_dr("bypass", 33, {$urandom, $urandom});
        check_ir("load undecoded", 5'd20);
        check_dr("undecoded as bypass", 33, {$urandom, $urandom});

        check_ir("load scratch", IR_SCRATCH);
        for (int k = 0; k < 20; k++) begin
            word = $urandom;
            check_dr($sformatf("scratch write %0d", k), 32, 64'(word));
            check_dr($sformatf("scratch read %0d", k), 32, 64'(word));
        end

        check_ir("load ctrl", IR_CTRL);
        ctrl_val = CTRL_WIDTH'($urandom);
        check_dr("ctrl write", CTRL_WIDTH, 64'(ctrl_val));
        @(negedge tck);
        post_result("ctrl_o after write", 64'(model_ctrl), 64'(ctrl));
        check_dr("ctrl read", CTRL_WIDTH, 64'(ctrl_val));

        check_ir("load status", IR_STATUS);
        check_dr("status initial read", STATUS_WIDTH, '0);
        pulse_status(12);
        check_dr("status sticky read", STATUS_WIDTH, 64'($urandom));
        check_dr("status cleared by read", STATUS_WIDTH, '1);
        pulse_status(8);
        check_dr("status after write", STATUS_WIDTH, '0);

        check_ir("load scratch before tms reset", IR_SCRATCH);
        abort_shift_by_tms(model_scratch);
        check_dr("idcode after tms reset", 32, 64'($urandom));
        @(negedge tck);
        post_result("ctrl_o kept over tms reset", 64'(model_ctrl), 64'(ctrl));
        check_ir("reload scratch", IR_SCRATCH);
        check_dr("scratch kept over tms reset", 32, 64'(model_scratch));

        repeat (2) @(negedge tck);  // Let the compare process drain
        $display("Summary: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && pass_count > 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge tck);
        $display("Timeout: the tests did not finish within %0d TCK cycles", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: hdl/jtag_dbg_top.sv
// Debug access port top: JTAG TAP joined to the debug register bank
module jtag_dbg_top
    import jtag_dbg_pkg::*;
#(
    parameter logic [31:0] IDCODE = 32'h0A5D_B001
) (
    // JTAG pins
    input  logic                    tck_i,
    input  logic                    trst_n_i,
    input  logic                    tms_i,
    input  logic                    tdi_i,
    output logic                    tdo_o,

    // Chip side
    input  logic [STATUS_WIDTH-1:0] status_i,
    output logic [CTRL_WIDTH-1:0]   ctrl_o
);

    ////////////////////////////////////////////////////////////
    // Custom register port between TAP and bank

    logic [CUST_ADDR_W-1:0] cust_rg_addr;
    logic                   cust_rg_val;
    logic [DR_WIDTH-1:0]    cust_rg_wdat;
    logic [DR_WIDTH-1:0]    cust_rg_rdat;
    logic                   cust_rg_re;
    logic                   cust_rg_we;

    jtag_tap #(
        .IDCODE             (IDCODE)
    ) jtag_tap_i (
        .tck_i              (tck_i),
        .trst_n_i           (trst_n_i),
        .tms_i              (tms_i),
        .tdi_i              (tdi_i),
        .tdo_o              (tdo_o),
        .cust_rg_addr_o     (cust_rg_addr),
        .cust_rg_val_o      (cust_rg_val),
        .cust_rg_dat_o      (cust_rg_wdat),
        .cust_rg_dat_i      (cust_rg_rdat),
        .cust_rg_dat_re_o   (cust_rg_re),
        .cust_rg_dat_we_o   (cust_rg_we)
    );

    // Registers visible to the debugger
    dbg_reg_bank dbg_reg_bank_i (
        .tck_i              (tck_i),
        .trst_n_i           (trst_n_i),
        .addr_i             (cust_rg_addr),
        .val_i              (cust_rg_val),
        .wdat_i             (cust_rg_wdat),
        .re_i               (cust_rg_re),
        .we_i               (cust_rg_we),
        .rdat_o             (cust_rg_rdat),
        .status_i           (status_i),
        .ctrl_o             (ctrl_o)
    );

endmodule

// File: hdl/dbg_reg_bank.sv
// Debug register bank: SCRATCH, CTRL and sticky STATUS behind the TAP
module dbg_reg_bank
    import jtag_dbg_pkg::*;
(
    input  logic                    tck_i,
    input  logic                    trst_n_i,

    // From the TAP
    input  logic [CUST_ADDR_W-1:0]  addr_i,
    input  logic                    val_i,
    input  logic [DR_WIDTH-1:0]     wdat_i,
    input  logic                    re_i,
    input  logic                    we_i,
    output logic [DR_WIDTH-1:0]     rdat_o,

    // Chip side
    input  logic [STATUS_WIDTH-1:0] status_i,
    output logic [CTRL_WIDTH-1:0]   ctrl_o
);

    localparam int SCRATCH_WIDTH = CUST_REG_WIDTHS[CUST_IDX_SCRATCH];

    ////////////////////////////////////////////////////////////
    // Access qualifiers

    logic wr_en;
    logic rd_status;

    // Strobes only count when the IR selects a bank register
    assign wr_en     = val_i && we_i;
    assign rd_status = val_i && re_i && (addr_i == CUST_IDX_STATUS);

    ////////////////////////////////////////////////////////////
    // Read/write registers

    logic [SCRATCH_WIDTH-1:0] scratch_q;
    logic [CTRL_WIDTH-1:0]    ctrl_q;

    always_ff @(posedge tck_i) begin
        if (!trst_n_i) begin
            scratch_q <= '0;
            ctrl_q    <= '0;
        end else if (wr_en) begin
            case (addr_i)
                CUST_IDX_SCRATCH: scratch_q <= wdat_i[SCRATCH_WIDTH-1:0];
                CUST_IDX_CTRL:    ctrl_q    <= wdat_i[CTRL_WIDTH-1:0];
                default: begin
                    // STATUS is read only
                    scratch_q <= scratch_q;
                    ctrl_q    <= ctrl_q;
                end
            endcase
        end
    end

    assign ctrl_o = ctrl_q;

    ////////////////////////////////////////////////////////////
    // Sticky status

    logic [STATUS_WIDTH-1:0] status_q;

    // Cleared by a read, new events in the same cycle survive
    always_ff @(posedge tck_i) begin
        if (!trst_n_i) begin
            status_q <= '0;
        end else if (rd_status) begin
            status_q <= status_i;
        end else begin
            status_q <= status_q | status_i;    // Collect pulses
        end
    end

    ////////////////////////////////////////////////////////////
    // Read mux, zero extended to the shift register

    always_comb begin
        case (addr_i)
            CUST_IDX_SCRATCH: rdat_o = DR_WIDTH'(scratch_q);
            CUST_IDX_CTRL:    rdat_o = DR_WIDTH'(ctrl_q);
            CUST_IDX_STATUS:  rdat_o = DR_WIDTH'(status_q);
            default:          rdat_o = '0;
        endcase
    end

endmodule

// File: hdl/jtag_tap.sv
// JTAG TAP controller with IDCODE, bypass and a port to custom data registers
module jtag_tap
    import jtag_dbg_pkg::*;
#(
    parameter logic [31:0] IDCODE = 32'h0A5D_B001     // Bit 0 set as the standard asks
) (
    input  logic                   tck_i,
    input  logic                   trst_n_i,
    input  logic                   tms_i,
    input  logic                   tdi_i,
    output logic                   tdo_o,

    // Custom register port
    output logic [CUST_ADDR_W-1:0] cust_rg_addr_o,
    output logic                   cust_rg_val_o,
    output logic [DR_WIDTH-1:0]    cust_rg_dat_o,
    input  logic [DR_WIDTH-1:0]    cust_rg_dat_i,
    output logic                   cust_rg_dat_re_o,
    output logic                   cust_rg_dat_we_o
);

    localparam int IDCODE_WIDTH = 32;
    localparam int DR_IDX_W     = $clog2(DR_WIDTH);

    ////////////////////////////////////////////////////////////
    // TAP state machine

    typedef enum logic [3:0] {
        TS_TEST_LOGIC_RST = 4'd0,
        TS_RUN_TEST_IDLE  = 4'd1,
        TS_SELECT_DR_SCAN = 4'd2,
        TS_CAPTURE_DR     = 4'd3,
        TS_SHIFT_DR       = 4'd4,
        TS_EXIT1_DR       = 4'd5,
        TS_PAUSE_DR       = 4'd6,
        TS_EXIT2_DR       = 4'd7,
        TS_UPDATE_DR      = 4'd8,
        TS_SELECT_IR_SCAN = 4'd9,
        TS_CAPTURE_IR     = 4'd10,
        TS_SHIFT_IR       = 4'd11,
        TS_EXIT1_IR       = 4'd12,
        TS_PAUSE_IR       = 4'd13,
        TS_EXIT2_IR       = 4'd14,
        TS_UPDATE_IR      = 4'd15
    } tap_state_e;

    tap_state_e tap_state;

    always_ff @(posedge tck_i) begin
        if (!trst_n_i) begin
            tap_state <= TS_TEST_LOGIC_RST;
        end else begin
            case (tap_state)
                TS_TEST_LOGIC_RST: tap_state <= tms_i ? TS_TEST_LOGIC_RST : TS_RUN_TEST_IDLE;
                TS_RUN_TEST_IDLE:  tap_state <= tms_i ? TS_SELECT_DR_SCAN : TS_RUN_TEST_IDLE;

                // DR column
                TS_SELECT_DR_SCAN: tap_state <= tms_i ? TS_SELECT_IR_SCAN : TS_CAPTURE_DR;
                TS_CAPTURE_DR:     tap_state <= tms_i ? TS_EXIT1_DR       : TS_SHIFT_DR;
                TS_SHIFT_DR:       tap_state <= tms_i ? TS_EXIT1_DR       : TS_SHIFT_DR;
                TS_EXIT1_DR:       tap_state <= tms_i ? TS_UPDATE_DR      : TS_PAUSE_DR;
                TS_PAUSE_DR:       tap_state <= tms_i ? TS_EXIT2_DR       : TS_PAUSE_DR;
                TS_EXIT2_DR:       tap_state <= tms_i ? TS_UPDATE_DR      : TS_SHIFT_DR;
                TS_UPDATE_DR:      tap_state <= tms_i ? TS_SELECT_DR_SCAN : TS_RUN_TEST_IDLE;

                // IR column
                TS_SELECT_IR_SCAN: tap_state <= tms_i ? TS_TEST_LOGIC_RST : TS_CAPTURE_IR;
                TS_CAPTURE_IR:     tap_state <= tms_i ? TS_EXIT1_IR       : TS_SHIFT_IR;
                TS_SHIFT_IR:       tap_state <= tms_i ? TS_EXIT1_IR       : TS_SHIFT_IR;
                TS_EXIT1_IR:       tap_state <= tms_i ? TS_UPDATE_IR      : TS_PAUSE_IR;
                TS_PAUSE_IR:       tap_state <= tms_i ? TS_EXIT2_IR       : TS_PAUSE_IR;
                TS_EXIT2_IR:       tap_state <= tms_i ? TS_UPDATE_IR      : TS_SHIFT_IR;
                TS_UPDATE_IR:      tap_state <= tms_i ? TS_SELECT_DR_SCAN : TS_RUN_TEST_IDLE;
                default:           tap_state <= TS_TEST_LOGIC_RST;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Instruction register

    logic [IR_WIDTH-1:0] ir_q;
    logic [IR_WIDTH-1:0] shift_ir;

    always_ff @(posedge tck_i) begin
        if (!trst_n_i) begin
            ir_q <= IR_IDCODE;
        end else if (tap_state == TS_TEST_LOGIC_RST) begin
            ir_q <= IR_IDCODE;                      // TMS reset path
        end else if (tap_state == TS_UPDATE_IR) begin
            ir_q <= shift_ir;
        end
    end

    // Shift stage loads the current instruction at Capture-IR
    always_ff @(posedge tck_i) begin
        case (tap_state)
            TS_CAPTURE_IR: shift_ir <= ir_q;
            TS_SHIFT_IR:   shift_ir <= {tdi_i, shift_ir[IR_WIDTH-1:1]};
            default:       shift_ir <= shift_ir;
        endcase
    end

    // Look the instruction up in the custom register table
    always_comb begin
        cust_rg_val_o  = 1'b0;
        cust_rg_addr_o = '0;
        for (int i = 0; i < NUM_CUST_REGS; i++) begin
            if (ir_q == CUST_REG_ADDRS[i]) begin
                cust_rg_val_o  = 1'b1;
                cust_rg_addr_o = CUST_ADDR_W'(i);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Data register

    logic                sel_idcode;
    logic [DR_IDX_W-1:0] dr_msb;        // Where TDI enters the chain
    logic [DR_WIDTH-1:0] shift_dr;

    assign sel_idcode = (ir_q == IR_IDCODE);

    // Chain length follows the selected register
    always_comb begin
        if (sel_idcode) begin
            dr_msb = DR_IDX_W'(IDCODE_WIDTH - 1);
        end else if (cust_rg_val_o) begin
            dr_msb = DR_IDX_W'(CUST_REG_WIDTHS[cust_rg_addr_o] - 1);
        end else begin
            dr_msb = '0;                        // Bypass is one bit
        end
    end

    always_ff @(posedge tck_i) begin
        case (tap_state)
            TS_CAPTURE_DR: begin
                if (sel_idcode) begin
                    shift_dr <= DR_WIDTH'(IDCODE);
                end else if (cust_rg_val_o) begin
                    shift_dr <= cust_rg_dat_i;      // Bank drives it this cycle
                end else begin
                    shift_dr <= '0;
                end
            end
            TS_SHIFT_DR: begin
                shift_dr         <= {tdi_i, shift_dr[DR_WIDTH-1:1]};
                shift_dr[dr_msb] <= tdi_i;          // Overrides the bit above
            end
            default: shift_dr <= shift_dr;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // TDO launched on the falling edge

    always_ff @(negedge tck_i) begin
        if (!trst_n_i) begin
            tdo_o <= 1'b0;
        end else begin
            case (tap_state)
                TS_SHIFT_IR: tdo_o <= shift_ir[0];
                TS_SHIFT_DR: tdo_o <= shift_dr[0];
                default:     tdo_o <= 1'b0;
            endcase
        end
    end

    // Plain state strobes that the bank qualifies with the valid flag
    assign cust_rg_dat_re_o = (tap_state == TS_CAPTURE_DR);
    assign cust_rg_dat_we_o = (tap_state == TS_UPDATE_DR);
    assign cust_rg_dat_o    = shift_dr;

endmodule

// File: hdl/jtag_dbg_pkg.sv
// Debug port constants: instruction codes, register widths and custom register table
package jtag_dbg_pkg;

    ////////////////////////////////////////////////////////////
    // Instruction set
    localparam int IR_WIDTH = 5;
    localparam int DR_WIDTH = 32;                           // Longest data register

    localparam logic [IR_WIDTH-1:0] IR_IDCODE  = 5'd1;      // Also loaded by reset
    localparam logic [IR_WIDTH-1:0] IR_SCRATCH = 5'd8;
    localparam logic [IR_WIDTH-1:0] IR_CTRL    = 5'd9;
    localparam logic [IR_WIDTH-1:0] IR_STATUS  = 5'd10;
    localparam logic [IR_WIDTH-1:0] IR_BYPASS  = '1;        // Undecoded codes act the same

    ////////////////////////////////////////////////////////////
    // Register widths in the bank
    localparam int CTRL_WIDTH   = 8;
    localparam int STATUS_WIDTH = 16;

    ////////////////////////////////////////////////////////////
    // Custom register table
    localparam int NUM_CUST_REGS = 3;
    localparam int CUST_ADDR_W   = 2;

    localparam logic [CUST_ADDR_W-1:0] CUST_IDX_SCRATCH = 2'd0;
    localparam logic [CUST_ADDR_W-1:0] CUST_IDX_CTRL    = 2'd1;
    localparam logic [CUST_ADDR_W-1:0] CUST_IDX_STATUS  = 2'd2;

    // Instruction code per index
    localparam logic [IR_WIDTH-1:0] CUST_REG_ADDRS [NUM_CUST_REGS] = '{
        IR_SCRATCH,
        IR_CTRL,
        IR_STATUS
    };

    // Chain length per index
    localparam int CUST_REG_WIDTHS [NUM_CUST_REGS] = '{
        32,
        CTRL_WIDTH,
        STATUS_WIDTH
    };

endpackage
